/* hdl/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// 32-bit word address is split as {unused, tag, set, line offset, byte offset}
// byte offset is always 2 bits, the rest follows below

`define LINE_ADDR_LEN 3     // word offset inside a line
`define SET_ADDR_LEN  3     // set index
`define TAG_ADDR_LEN  6     // tag bits kept per way

`define WAY_CNT       3     // ways per set
`define WAY_IDX_LEN   2     // wide enough for way index and fill count

`define LINE_SIZE     8     // words per line, 2**LINE_ADDR_LEN
`define SET_SIZE      8     // sets, 2**SET_ADDR_LEN

// main memory is addressed in whole lines
`define MEM_ADDR_LEN  9     // tag + set

// request held this many cycles before gnt
`define MEM_LATENCY   6

`endif

/* hdl/cache_pkg.sv */
package cache_pkg;

`include "cache_params.svh"

    // controller states
    typedef enum logic [1:0] {
        idle,           // ready, hits served here
        swap_out,       // dirty victim written back
        swap_in,        // line read from memory
        swap_in_ok      // fetched line written into the cache
    } cache_state_e;

    typedef logic [31:0]                  word_t;
    typedef logic [`TAG_ADDR_LEN-1:0]     tag_t;
    typedef logic [`SET_ADDR_LEN-1:0]     set_t;
    typedef logic [`WAY_IDX_LEN-1:0]      way_t;
    typedef logic [`LINE_ADDR_LEN-1:0]    offset_t;
    typedef logic [`MEM_ADDR_LEN-1:0]     mem_addr_t;

    // word 0 sits in the low 32 bits
    typedef logic [`LINE_SIZE*32-1:0]     line_t;

endpackage

/* hdl/tag_array.sv */
`timescale 1ns/100ps

`include "cache_params.svh"

module tag_array import cache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  set_t   req_set,         // set of the live request
    input  tag_t   req_tag,         // tag of the live request
    input  logic   fill,            // line fill strobe
    input  set_t   fill_set,        // latched set of the fill
    input  tag_t   fill_tag,        // latched tag of the fill
    input  way_t   fill_way,        // way picked by the recency list
    input  logic   mark_dirty,      // write hit strobe
    input  way_t   hit_way_in,      // way written by the hit
    input  way_t   victim_way,      // way that a miss would replace
    output logic   hit,
    output way_t   hit_way,
    output logic   victim_dirty,
    output tag_t   victim_tag
);

    tag_t               tags  [`SET_SIZE][`WAY_CNT];   // tag per way
    logic [`WAY_CNT-1:0] valid [`SET_SIZE];            // one bit per way
    logic [`WAY_CNT-1:0] dirty [`SET_SIZE];

    // all ways of the set compared at once
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `WAY_CNT; w++) begin
            if (valid[req_set][w] && tags[req_set][w] == req_tag) begin
                hit     = 1'b1;             // at most one way matches
                hit_way = way_t'(w);
            end
        end
    end

    // a free way is never valid, so never written back
    assign victim_dirty = valid[req_set][victim_way] & dirty[req_set][victim_way];
    assign victim_tag   = tags[req_set][victim_way];   // forms the write-back address

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[fill_set][fill_way] <= fill_tag;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < `SET_SIZE; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
            end
        end else begin
            if (fill) begin
                valid[fill_set][fill_way] <= 1'b1;     // fresh line from memory
                dirty[fill_set][fill_way] <= 1'b0;     // matches memory now
            end
            if (mark_dirty) begin
                dirty[req_set][hit_way_in] <= 1'b1;    // line differs from memory
            end
        end
    end

endmodule

/* hdl/lru_list.sv */
`timescale 1ns/100ps

`include "cache_params.svh"

module lru_list import cache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  set_t   req_set,         // set of the live request
    input  logic   touch,           // hit in idle
    input  way_t   touch_way,       // the way that hit
    input  logic   replace,         // miss in idle
    input  set_t   fill_set,        // latched set of the fill
    output way_t   victim_way,
    output way_t   fill_way
);

    // head is least recent, tail is most recent
    way_t   prev_ptr [`SET_SIZE][`WAY_CNT];
    way_t   next_ptr [`SET_SIZE][`WAY_CNT];
    way_t   head     [`SET_SIZE];
    way_t   tail     [`SET_SIZE];
    way_t   count    [`SET_SIZE];          // ways in use, 0 to WAY_CNT

    way_t   req_head;
    way_t   req_tail;
    way_t   req_count;
    way_t   hit_prev;
    way_t   hit_next;
    logic   set_full;

    assign req_head  = head[req_set];
    assign req_tail  = tail[req_set];
    assign req_count = count[req_set];
    assign hit_prev  = prev_ptr[req_set][touch_way];
    assign hit_next  = next_ptr[req_set][touch_way];
    assign set_full  = (req_count == way_t'(`WAY_CNT));

    // free ways are taken in order 0, 1, 2
    assign victim_way = set_full ? req_head : req_count;
    // replace moves the chosen way to the tail, so the fill lands there
    assign fill_way   = tail[fill_set];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < `SET_SIZE; s++) begin
                head[s]  <= '0;
                tail[s]  <= '0;
                count[s] <= '0;
                for (int w = 0; w < `WAY_CNT; w++) begin
                    prev_ptr[s][w] <= '0;
                    next_ptr[s][w] <= '0;
                end
            end
        end else if (touch) begin
            // a tail hit or a single node leaves the order as it is
            if (req_count > way_t'(1) && touch_way != req_tail) begin
                if (touch_way == req_head) begin
                    head[req_set] <= hit_next;                     // drop the head
                end else begin
                    next_ptr[req_set][hit_prev] <= hit_next;       // bridge over the way
                    prev_ptr[req_set][hit_next] <= hit_prev;
                end
                next_ptr[req_set][req_tail]  <= touch_way;         // append at the tail
                prev_ptr[req_set][touch_way] <= req_tail;
                tail[req_set]                <= touch_way;
            end
        end else if (replace) begin
            if (!set_full) begin
                if (req_count == '0) begin
                    head[req_set] <= req_count;                    // first node of the set
                end else begin
                    next_ptr[req_set][req_tail]  <= req_count;
                    prev_ptr[req_set][req_count] <= req_tail;
                end
                tail[req_set]  <= req_count;
                count[req_set] <= req_count + 1'b1;
            end else begin
                // the old head is evicted and becomes most recent
                head[req_set]               <= next_ptr[req_set][req_head];
                next_ptr[req_set][req_tail] <= req_head;
                prev_ptr[req_set][req_head] <= req_tail;
                tail[req_set]               <= req_head;
            end
        end
    end

endmodule

/* hdl/cache_ctrl.sv */
`timescale 1ns/100ps

`include "cache_params.svh"

module cache_ctrl import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  word_t       addr,           // byte address from the CPU
    input  logic        rd_req,
    input  logic        wr_req,
    input  word_t       wr_data,
    output logic        miss,
    output word_t       rd_data,
    input  logic        hit,
    input  way_t        hit_way,
    input  logic        victim_dirty,
    input  tag_t        victim_tag,
    output set_t        req_set,
    output tag_t        req_tag,
    output logic        fill,
    output set_t        fill_set,
    output tag_t        fill_tag,
    output logic        mark_dirty,
    input  way_t        victim_way,
    input  way_t        fill_way,
    output logic        touch,
    output logic        replace,
    input  logic        mem_gnt,
    input  line_t       mem_rd_line,
    output mem_addr_t   mem_addr,
    output logic        mem_rd_req,
    output logic        mem_wr_req,
    output line_t       mem_wr_line
);

    cache_state_e   state;
    offset_t        req_offset;
    logic           req;
    logic           hit_idle;           // request served this cycle
    logic           do_read;
    logic           do_write;
    mem_addr_t      wb_addr;            // line address of the dirty victim

    line_t          data_mem [`SET_SIZE][`WAY_CNT];    // line storage

    // {unused, tag, set, offset, byte}
    assign req_offset = addr[2 +: `LINE_ADDR_LEN];
    assign req_set    = addr[2 + `LINE_ADDR_LEN +: `SET_ADDR_LEN];
    assign req_tag    = addr[2 + `LINE_ADDR_LEN + `SET_ADDR_LEN +: `TAG_ADDR_LEN];

    assign req      = rd_req | wr_req;
    assign hit_idle = req & hit & (state == idle);
    assign do_read  = hit_idle & rd_req;                // read wins if both are set
    assign do_write = hit_idle & wr_req & ~rd_req;

    assign miss       = req & ~(hit & (state == idle));
    assign touch      = hit_idle;                      // move hit way to the tail
    assign replace    = req & ~hit & (state == idle);  // start of a fill
    assign mark_dirty = do_write;
    assign fill       = (state == swap_in_ok);

    // memory request levels come straight from the state
    assign mem_rd_req = (state == swap_in);
    assign mem_wr_req = (state == swap_out);
    assign mem_addr   = mem_rd_req ? {fill_tag, fill_set} :
                        mem_wr_req ? wb_addr : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (replace) begin
                        state <= victim_dirty ? swap_out : swap_in;   // write back first
                    end
                end
                swap_out: begin
                    if (mem_gnt) begin
                        state <= swap_in;       // victim line is in memory
                    end
                end
                swap_in: begin
                    if (mem_gnt) begin
                        state <= swap_in_ok;    // rd_line holds the new line
                    end
                end
                swap_in_ok: begin
                    state <= idle;              // request hits next cycle
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // data path
    always_ff @(posedge clk) begin
        if (do_read) begin
            rd_data <= data_mem[req_set][hit_way][{req_offset, 5'b0} +: 32];
        end
        if (do_write) begin
            data_mem[req_set][hit_way][{req_offset, 5'b0} +: 32] <= wr_data;
        end
        if (replace) begin
            fill_set    <= req_set;                      // held for the whole fill
            fill_tag    <= req_tag;
            wb_addr     <= {victim_tag, req_set};
            mem_wr_line <= data_mem[req_set][victim_way];   // snapshot of the victim
        end
        if (state == swap_in_ok) begin
            data_mem[fill_set][fill_way] <= mem_rd_line;   // latched set, not live one
        end
    end

endmodule

/* hdl/main_mem.sv */
`timescale 1ns/100ps

`include "cache_params.svh"

module main_mem import cache_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  mem_addr_t   addr,           // line address {tag, set}
    input  logic        rd_req,
    input  logic        wr_req,
    input  line_t       wr_line,
    output logic        gnt,
    output line_t       rd_line
);

    localparam int unsigned LAT_W = $clog2(`MEM_LATENCY);

    line_t              mem_array [1 << `MEM_ADDR_LEN];
    logic [LAT_W-1:0]   lat_cnt;            // cycles the request has been held
    logic               req;

    assign req = rd_req | wr_req;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            gnt     <= 1'b0;
            lat_cnt <= '0;
            rd_line <= '0;
            // every word holds its own word address (byte address / 4)
            for (int i = 0; i < (1 << `MEM_ADDR_LEN); i++) begin
                for (int j = 0; j < `LINE_SIZE; j++) begin
                    mem_array[i][j*32 +: 32] <= word_t'(i * `LINE_SIZE + j);
                end
            end
        end else if (req && !gnt) begin
            if (lat_cnt == LAT_W'(`MEM_LATENCY - 1)) begin
                gnt     <= 1'b1;                // single-cycle pulse
                lat_cnt <= '0;
                if (wr_req) begin
                    mem_array[addr] <= wr_line;     // write commits on grant
                end
                if (rd_req) begin
                    rd_line <= mem_array[addr];     // held until the next read grant
                end
            end else begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end else begin
            gnt <= 1'b0;
            if (!req) begin
                lat_cnt <= '0;                  // dropped request restarts the count
            end
        end
    end

endmodule

/* hdl/cache_top.sv */
`timescale 1ns/100ps

module cache_top import cache_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  word_t   addr,
    input  logic    rd_req,
    input  logic    wr_req,
    input  word_t   wr_data,
    output logic    miss,
    output word_t   rd_data
);

    set_t       req_set;
    tag_t       req_tag;
    logic       fill;
    set_t       fill_set;
    tag_t       fill_tag;
    logic       mark_dirty;
    logic       hit;
    way_t       hit_way;            // also the way moved by a touch
    logic       victim_dirty;
    tag_t       victim_tag;
    way_t       victim_way;
    way_t       fill_way;
    logic       touch;
    logic       replace;
    mem_addr_t  mem_addr;
    logic       mem_rd_req;
    logic       mem_wr_req;
    line_t      mem_wr_line;
    logic       mem_gnt;
    line_t      mem_rd_line;

    cache_ctrl u_ctrl (
        .clk(clk), .rst(rst), .addr(addr), .rd_req(rd_req), .wr_req(wr_req),
        .wr_data(wr_data), .miss(miss), .rd_data(rd_data), .hit(hit), .hit_way(hit_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag), .req_set(req_set),
        .req_tag(req_tag), .fill(fill), .fill_set(fill_set), .fill_tag(fill_tag),
        .mark_dirty(mark_dirty), .victim_way(victim_way), .fill_way(fill_way),
        .touch(touch), .replace(replace), .mem_gnt(mem_gnt), .mem_rd_line(mem_rd_line),
        .mem_addr(mem_addr), .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req),
        .mem_wr_line(mem_wr_line)
    );

    tag_array u_tags (
        .clk(clk), .rst(rst), .req_set(req_set), .req_tag(req_tag), .fill(fill),
        .fill_set(fill_set), .fill_tag(fill_tag), .fill_way(fill_way),
        .mark_dirty(mark_dirty), .hit_way_in(hit_way), .victim_way(victim_way),
        .hit(hit), .hit_way(hit_way), .victim_dirty(victim_dirty), .victim_tag(victim_tag)
    );

    lru_list u_lru (
        .clk(clk), .rst(rst), .req_set(req_set), .touch(touch), .touch_way(hit_way),
        .replace(replace), .fill_set(fill_set), .victim_way(victim_way), .fill_way(fill_way)
    );

    main_mem u_mem (
        .clk(clk), .rst(rst), .addr(mem_addr), .rd_req(mem_rd_req), .wr_req(mem_wr_req),
        .wr_line(mem_wr_line), .gnt(mem_gnt), .rd_line(mem_rd_line)
    );

endmodule

/* testbench/tb_cache.sv */
`timescale 1ns/100ps

`include "cache_params.svh"

module tb_cache import cache_pkg::*; ();

    localparam int WIDX_LEN  = `LINE_ADDR_LEN + `SET_ADDR_LEN + `TAG_ADDR_LEN;   // word index bits
    localparam int SET_SHIFT = `LINE_ADDR_LEN + 2;
    localparam int TAG_SHIFT = `SET_ADDR_LEN + `LINE_ADDR_LEN + 2;
    localparam int TIMEOUT   = 200;     // cycles per wait
    localparam int RAND_OPS  = 400;

    logic   clk;
    logic   rst;
    word_t  addr;
    logic   rd_req;
    logic   wr_req;
    word_t  wr_data;
    logic   miss;
    word_t  rd_data;

    word_t  ref_mem [1 << WIDX_LEN];    // mirror of main memory plus cache writes
    word_t  exp_q [$];                  // expected words of completed reads
    string  name_q [$];
    word_t  lcg_state;
    logic   hit_flag;
    word_t  rnd;
    word_t  rnd_data;
    word_t  a;
    int     drain;

    cache_top u_dut (
        .clk(clk), .rst(rst), .addr(addr), .rd_req(rd_req), .wr_req(wr_req),
        .wr_data(wr_data), .miss(miss), .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;             // 40 ns period
        end
    end

    function automatic word_t lcg_next(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // {tag, set, word offset, byte offset}
    function automatic word_t make_addr(input int tag, input int set, input int off);
        return word_t'((tag << TAG_SHIFT) | (set << SET_SHIFT) | (off << 2));
    endfunction

    // memory holds word addresses at reset, writes overwrite them
    function automatic word_t expected_read(input word_t byte_addr);
        return ref_mem[byte_addr[2 +: WIDX_LEN]];
    endfunction

    task automatic check(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // holds the request until an edge with miss low, called just after a rising edge
    task automatic do_request(input string name, input logic write, input word_t req_addr,
                              input word_t data, output logic first_hit);
        int     cycles;
        logic   done;
        cycles    = 0;
        done      = 1'b0;
        first_hit = 1'b0;
        addr      = req_addr;
        rd_req    = ~write;
        wr_req    = write;
        wr_data   = data;
        while (!done) begin
            @(negedge clk);                     // miss is settled mid-cycle
            if (!miss) begin
                first_hit = (cycles == 0);
                done      = 1'b1;
            end else begin
                cycles++;
                if (cycles > TIMEOUT) begin
                    $display("request to address %h was still missing after %0d cycles",
                             req_addr, TIMEOUT);
                    $display("Testbench failed");
                    $fatal(1, "request timeout");
                end
            end
            @(posedge clk);
            #2;
        end
        if (write) begin
            ref_mem[req_addr[2 +: WIDX_LEN]] = data;
        end else begin
            exp_q.push_back(expected_read(req_addr));
            name_q.push_back(name);
        end
        rd_req = 1'b0;
        wr_req = 1'b0;
    endtask

    // rd_data is compared half a cycle after the completing edge
    initial begin
        forever begin
            @(negedge clk);
            if (exp_q.size() > 0) begin
                check(name_q.pop_front(), exp_q.pop_front(), rd_data);
            end
        end
    end

    initial begin
        rst       = 1'b1;
        addr      = '0;
        rd_req    = 1'b0;
        wr_req    = 1'b0;
        wr_data   = '0;
        lcg_state = 32'h19a0f525;
        for (int i = 0; i < (1 << WIDX_LEN); i++) begin
            ref_mem[i] = word_t'(i);
        end
        repeat (5) @(posedge clk);
        #2 rst = 1'b0;

        // idle after reset
        @(negedge clk);
        check("reset miss", 32'd0, word_t'(miss));
        check("reset mem_rd_req", 32'd0, word_t'(u_dut.mem_rd_req));
        check("reset mem_wr_req", 32'd0, word_t'(u_dut.mem_wr_req));
        check("reset gnt", 32'd0, word_t'(u_dut.mem_gnt));
        @(posedge clk);
        #2;

        // cold read fills the line, data is the word address
        a = make_addr(0, 0, 3);
        do_request("first read", 1'b0, a, '0, hit_flag);
        check("first read miss", 32'd0, word_t'(hit_flag));
        check("first read value", a >> 2, rd_data);

        // write then read back the same word
        a = make_addr(7, 1, 5);
        do_request("write word", 1'b1, a, 32'hcafe_0001, hit_flag);
        do_request("read after write", 1'b0, a, '0, hit_flag);
        check("read after write hit", 32'd1, word_t'(hit_flag));

        // four tags in set 2, the first one is evicted dirty
        for (int t = 1; t <= 4; t++) begin
            do_request("fill set 2", 1'b1, make_addr(t, 2, 3), 32'h5e70_0000 + t, hit_flag);
        end
        do_request("write-back read", 1'b0, make_addr(1, 2, 3), '0, hit_flag);
        check("write-back read miss", 32'd0, word_t'(hit_flag));

        // recency order in set 5, tags 10 to 13 as A to D
        do_request("lru A", 1'b0, make_addr(10, 5, 0), '0, hit_flag);
        do_request("lru B", 1'b0, make_addr(11, 5, 1), '0, hit_flag);
        do_request("lru C", 1'b0, make_addr(12, 5, 2), '0, hit_flag);
        do_request("lru A again", 1'b0, make_addr(10, 5, 4), '0, hit_flag);
        check("lru A again hit", 32'd1, word_t'(hit_flag));
        do_request("lru D", 1'b0, make_addr(13, 5, 6), '0, hit_flag);   // evicts B
        do_request("lru A kept", 1'b0, make_addr(10, 5, 7), '0, hit_flag);
        check("lru A kept hit", 32'd1, word_t'(hit_flag));
        do_request("lru B evicted", 1'b0, make_addr(11, 5, 1), '0, hit_flag);
        check("lru B evicted miss", 32'd0, word_t'(hit_flag));

        // random mix, five tags over sets 6 and 7 keep evicting
        for (int n = 0; n < RAND_OPS; n++) begin
            lcg_state = lcg_next(lcg_state);
            rnd       = lcg_state;
            lcg_state = lcg_next(lcg_state);
            rnd_data  = lcg_state;
            a = make_addr(int'(rnd[15:8]) % 5, 6 + int'(rnd[16]), int'(rnd[19:17]));
            do_request("random", rnd[20], a, rnd_data, hit_flag);
        end

        drain = 0;
        while (exp_q.size() > 0) begin
            @(posedge clk);
            drain++;
            if (drain > TIMEOUT) begin
                $display("read results were never compared");
                $display("Testbench failed");
                $fatal(1, "compare timeout");
            end
        end
        @(posedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hdl
hdl/cache_pkg.sv
hdl/tag_array.sv
hdl/lru_list.sv
hdl/cache_ctrl.sv
hdl/main_mem.sv
hdl/cache_top.sv
testbench/tb_cache.sv

/* Makefile */
# Verilator flow for the cache testbench
VERILATOR  ?= verilator
TOP        ?= tb_cache
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/100ps
JOBS       ?= 0
VFLAGS     ?= --timing --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only
SIM_FLAGS  ?= --binary -j $(JOBS)

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# exit status of the simulation is the pass or fail result
sim: build
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
